// ==== Makefile ====
SIM      = verilator
TOP      = execUnit_tb
FLIST    = flist.f
OBJDIR   = obj_dir
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJDIR)
PASS_MSG = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FLIST)

# Exit status comes from the search for the pass message
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== flist.f ====
+incdir+include
verilog/aluPkg.sv
verilog/reqAckReceiver.sv
verilog/opDecoder.sv
verilog/operandSelect.sv
verilog/alu.sv
verilog/reqAckSender.sv
verilog/execUnit.sv
test/execUnit_tb.sv

// ==== include/alu_params.svh ====
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// Datapath sizing for the execute unit

// One MIPS word for operands and results
`define ALU_DATA_WIDTH 32

// Shift amount taken from the shamt field or the low bits of A
`define ALU_SHAMT_WIDTH 5

// Register index for rs, rt and rd
`define ALU_REG_IDX_WIDTH 5

`endif

// ==== test/execUnit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module execUnit_tb;

    import aluPkg::*;

    localparam int CyclesPerInstr = 40;   // Worst case per item with long ack delays
    localparam int CycleSlack     = 100;  // Reset and pipeline drain
    localparam int ShortDelay     = 2;
    localparam int LongDelay      = 12;   // Back-pressure phase

    logic    clk;
    logic    arstN;
    logic    inReq;
    logic    inAck;
    word_t   inInstr;
    word_t   inA;
    word_t   inB;
    logic    outReq;
    logic    outAck;
    word_t   outResult;
    logic    outZero;
    logic    outTaken;
    logic    outRegWrite;
    regIdx_t outDest;

    word_t       instrQ[$];          // Stimulus list
    word_t       aQ[$];
    word_t       bQ[$];
    logic [39:0] expQ[$];            // {result, zero, taken, regWrite, dest}
    logic [39:0] expRec;
    int          checkErrors = 0;
    int          protoErrors = 0;
    int          recvCount   = 0;
    int          phaseBStart = 0;    // First item of the back-pressure phase
    int          cycles      = 0;
    int          cycleLimit  = 0;
    logic        prevInReq   = 1'b0;
    logic        prevInAck   = 1'b0;
    logic        prevOutReq  = 1'b0;
    logic        prevOutAck  = 1'b0;
    logic [5:0]  rFuncts [16] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
                                  6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07};
    logic [5:0]  iOpcodes [10] = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f,
                                   6'h04, 6'h05};

    execUnit i_dut (
        .clk(clk), .arstN(arstN), .inReq(inReq), .inAck(inAck), .inInstr(inInstr),
        .inA(inA), .inB(inB), .outReq(outReq), .outAck(outAck), .outResult(outResult),
        .outZero(outZero), .outTaken(outTaken), .outRegWrite(outRegWrite), .outDest(outDest)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;  // 20 ns period

    function automatic word_t rType(input logic [4:0] rs, input logic [4:0] rt,
                                    input logic [4:0] rd, input logic [4:0] sh,
                                    input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t iType(input logic [5:0] opc, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    // Signed compare by flipping sign bits into an unsigned compare
    function automatic word_t lessSigned(input word_t x, input word_t y);
        return {31'h0, (x ^ 32'h8000_0000) < (y ^ 32'h8000_0000)};
    endfunction

    function automatic word_t shiftArith(input word_t v, input logic [4:0] n);
        return v[31] ? ~(~v >> n) : (v >> n);  // Ones shifted in for negatives
    endfunction

    // Expected outcome of one instruction from the MIPS rules
    function automatic logic [39:0] refExec(input word_t instr, input word_t a, input word_t b);
        logic [5:0]  opc;
        logic [5:0]  fn;
        logic [4:0]  sh;
        logic [15:0] imm;
        word_t       sImm;
        word_t       zImm;
        word_t       res;
        logic        known;
        logic        isBr;
        logic        tk;
        opc   = instr[31:26];
        fn    = instr[5:0];
        sh    = instr[10:6];
        imm   = instr[15:0];
        sImm  = {{16{imm[15]}}, imm};
        zImm  = {16'h0000, imm};
        res   = '0;
        known = 1'b1;
        isBr  = 1'b0;
        tk    = 1'b0;
        if (opc == 6'h00) begin
            case (fn)
                6'h20, 6'h21: res = a + b;
                6'h22, 6'h23: res = a - b;
                6'h24:        res = a & b;
                6'h25:        res = a | b;
                6'h26:        res = a ^ b;
                6'h27:        res = ~(a | b);
                6'h2a:        res = lessSigned(a, b);
                6'h2b:        res = {31'h0, a < b};
                6'h00:        res = b << sh;
                6'h02:        res = b >> sh;
                6'h03:        res = shiftArith(b, sh);
                6'h04:        res = b << a[4:0];        // Only low five bits of rs
                6'h06:        res = b >> a[4:0];
                6'h07:        res = shiftArith(b, a[4:0]);
                default:      known = 1'b0;
            endcase
        end else begin
            case (opc)
                6'h04: begin
                    res  = a - b;
                    isBr = 1'b1;
                    tk   = (a == b);
                end
                6'h05: begin
                    res  = a - b;
                    isBr = 1'b1;
                    tk   = (a != b);
                end
                6'h08, 6'h09: res = a + sImm;
                6'h0a:        res = lessSigned(a, sImm);
                6'h0b:        res = {31'h0, a < sImm};  // Sign extended, unsigned compare
                6'h0c:        res = a & zImm;
                6'h0d:        res = a | zImm;
                6'h0e:        res = a ^ zImm;
                6'h0f:        res = {imm, 16'h0000};
                default:      known = 1'b0;
            endcase
        end
        return {res, res == '0, tk, known && !isBr, (opc == 6'h00) ? instr[15:11] : instr[20:16]};
    endfunction

    function automatic word_t randInstr();
        int pick;
        pick = $urandom_range(0, 27);
        if (pick < 16) begin
            return rType(5'($urandom), 5'($urandom), 5'($urandom), 5'($urandom), rFuncts[pick]);
        end else if (pick < 26) begin
            return iType(iOpcodes[pick-16], 5'($urandom), 5'($urandom), 16'($urandom));
        end
        return $urandom;  // Raw word, often an unknown encoding
    endfunction

    task automatic addCase(input word_t instr, input word_t a, input word_t b);
        instrQ.push_back(instr);
        aQ.push_back(a);
        bQ.push_back(b);
    endtask

    task automatic buildTests();
        word_t a;
        // Random R-type and I-type coverage
        foreach (rFuncts[i]) begin
            repeat (4) addCase(rType(5'($urandom), 5'($urandom), 5'($urandom), 5'($urandom),
                                     rFuncts[i]), $urandom, $urandom);
        end
        foreach (iOpcodes[i]) begin
            repeat (4) begin
                a = $urandom;
                addCase(iType(iOpcodes[i], 5'($urandom), 5'($urandom), 16'($urandom)), a,
                        ($urandom_range(0, 1) == 1) ? a : word_t'($urandom));  // Half equal
            end
        end
        // Directed corners
        addCase(rType(5'd1, 5'd2, 5'd3, 5'd0, 6'h2a), 32'h8000_0000, 32'h0000_0001);  // slt 1
        addCase(rType(5'd1, 5'd2, 5'd4, 5'd0, 6'h2b), 32'h8000_0000, 32'h0000_0001);  // sltu 0
        addCase(rType(5'd1, 5'd2, 5'd5, 5'd0, 6'h2b), 32'h0000_0001, 32'hffff_ffff);
        addCase(rType(5'd1, 5'd2, 5'd6, 5'd0, 6'h21), 32'h7fff_ffff, 32'h0000_0001);  // Wraps
        addCase(rType(5'd0, 5'd2, 5'd7, 5'd4, 6'h03), 32'h0, 32'h8000_00f0);          // sra
        addCase(rType(5'd1, 5'd2, 5'd8, 5'd0, 6'h04), 32'hffff_ffe3, 32'h0000_00ff);
        addCase(rType(5'd1, 5'd2, 5'd9, 5'd0, 6'h06), 32'hffff_ffe3, 32'hf000_0000);
        addCase(rType(5'd1, 5'd2, 5'd10, 5'd0, 6'h07), 32'h0000_0021, 32'h8000_0000);
        addCase(rType(5'd1, 5'd2, 5'd11, 5'd0, 6'h07), 32'h0000_0020, 32'h8123_4567); // By 0
        addCase(iType(6'h08, 5'd1, 5'd12, 16'h8000), 32'h0001_0000, 32'h0);
        addCase(iType(6'h0a, 5'd1, 5'd13, 16'hffff), 32'hffff_fffe, 32'h0);            // -2 < -1
        addCase(iType(6'h0b, 5'd1, 5'd14, 16'hffff), 32'h0000_0005, 32'h0);
        addCase(iType(6'h0c, 5'd1, 5'd15, 16'hffff), 32'hdead_beef, 32'h0);
        addCase(iType(6'h0d, 5'd1, 5'd16, 16'h8000), 32'h0, 32'h0);
        addCase(iType(6'h0e, 5'd1, 5'd17, 16'hffff), 32'hffff_0000, 32'h0);
        addCase(iType(6'h0f, 5'd0, 5'd18, 16'h8001), 32'h1234_5678, 32'h0);
        addCase(iType(6'h04, 5'd1, 5'd2, 16'h0010), 32'h5555_aaaa, 32'h5555_aaaa);     // beq taken
        addCase(iType(6'h04, 5'd1, 5'd2, 16'h0010), 32'h5555_aaaa, 32'h5555_aaab);
        addCase(iType(6'h05, 5'd1, 5'd2, 16'hfff0), 32'h0000_0007, 32'h0000_0007);
        addCase(iType(6'h05, 5'd1, 5'd2, 16'hfff0), 32'h0000_0007, 32'h0000_0008);     // bne taken
        addCase(iType(6'h3f, 5'd1, 5'd19, 16'h1234), 32'h1111_1111, 32'h2222_2222);    // Unknown
        addCase(rType(5'd1, 5'd2, 5'd20, 5'd3, 6'h01), 32'h1111_1111, 32'h2222_2222);
        addCase(iType(6'h02, 5'd1, 5'd21, 16'h0040), 32'h3333_3333, 32'h4444_4444);    // j unsupported
        phaseBStart = instrQ.size();
        repeat (40) addCase(randInstr(), $urandom, $urandom);
    endtask

    task automatic sendInstr(input word_t instr, input word_t a, input word_t b);
        inInstr <= instr;
        inA     <= a;
        inB     <= b;
        inReq   <= 1'b1;
        @(posedge clk);
        while (!inAck) @(posedge clk);
        expQ.push_back(refExec(instr, a, b));  // Accepted by the DUT
        inReq <= 1'b0;
        @(posedge clk);
        while (inAck) @(posedge clk);        // Back to zero before next item
    endtask

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            checkErrors++;
        end
    endtask

    task automatic printCounts();
        $display("Errors: %0d value, %0d protocol, %0d of %0d results received",
                 checkErrors, protoErrors, recvCount, instrQ.size());
    endtask

    // Source and overall sequencing
    initial begin
        inReq   = 1'b0;
        inInstr = '0;
        inA     = '0;
        inB     = '0;
        outAck  = 1'b0;
        arstN   = 1'b0;
        void'($urandom(32'h9a2a));
        buildTests();
        cycleLimit = instrQ.size() * CyclesPerInstr + CycleSlack;
        repeat (3) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        foreach (instrQ[i]) sendInstr(instrQ[i], aQ[i], bQ[i]);
        while (recvCount < instrQ.size()) @(posedge clk);
        repeat (50) @(posedge clk);          // Window for duplicates
        if (expQ.size() != 0) begin
            $display("ERROR: %0d expected results were never delivered", expQ.size());
            protoErrors++;
        end
        printCounts();
        if (checkErrors + protoErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Sink with random ack delays, longer in the back-pressure phase
    initial begin
        int maxDelay;
        @(posedge arstN);
        forever begin
            @(posedge clk);
            if (outReq) begin
                maxDelay = (recvCount > phaseBStart) ? LongDelay : ShortDelay;
                repeat ($urandom_range(0, maxDelay)) @(posedge clk);
                outAck <= 1'b1;
                while (outReq) @(posedge clk);
                repeat ($urandom_range(0, maxDelay)) @(posedge clk);
                outAck <= 1'b0;
            end
        end
    end

    // Protocol monitor and result compare at the stable falling edge
    always @(negedge clk) begin
        if (arstN) begin
            if (inAck && !prevInAck && !prevInReq) begin
                $display("ERROR at %0t: inAck rose without a pending inReq", $time);
                protoErrors++;
            end
            if (outReq && !prevOutReq) begin
                if (prevOutAck) begin
                    $display("ERROR at %0t: outReq rose while outAck was still high", $time);
                    protoErrors++;
                end
                if (expQ.size() == 0) begin
                    $display("ERROR at %0t: result delivered with nothing outstanding", $time);
                    protoErrors++;
                end else begin
                    expRec = expQ.pop_front();
                    checkVal("outResult", outResult, expRec[39:8]);
                    checkVal("outZero", 32'(outZero), 32'(expRec[7]));
                    checkVal("outTaken", 32'(outTaken), 32'(expRec[6]));
                    checkVal("outRegWrite", 32'(outRegWrite), 32'(expRec[5]));
                    checkVal("outDest", 32'(outDest), 32'(expRec[4:0]));
                end
                recvCount++;
            end
        end
        prevInReq  = inReq;
        prevInAck  = inAck;
        prevOutReq = outReq;
        prevOutAck = outAck;
    end

    // Cycle budget scaled by test length
    always @(posedge clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("ERROR: run did not finish within %0d cycles", cycleLimit);
            printCounts();
            $display("*** FAILED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        inVld,
    input  aluPkg::aluOp_t              op,
    input  logic [`ALU_SHAMT_WIDTH-1:0] shamt,
    input  aluPkg::regIdx_t             dest,
    input  logic                        regWrite,
    input  aluPkg::word_t               a,
    input  aluPkg::word_t               b,
    input  logic                        stall,
    output logic                        vld,
    output aluPkg::word_t               result,
    output logic                        zero,
    output logic                        taken,
    output aluPkg::regIdx_t             destOut,
    output logic                        regWriteOut,
    output logic                        stallUp
);

    import aluPkg::*;

    logic                        load;
    logic                        isBranch;
    logic                        resZero;
    logic [`ALU_SHAMT_WIDTH-1:0] varSh;   // Low bits of A for variable shifts
    word_t                       aluRes;

    assign load     = !vld || !stall;
    assign stallUp  = vld && stall;
    assign isBranch = (op == ALU_BEQ) || (op == ALU_BNE);
    assign varSh    = a[`ALU_SHAMT_WIDTH-1:0];
    assign resZero  = (aluRes == '0);

    always_comb begin
        case (op)
            ALU_ADD, ALU_ADDU: aluRes = a + b;     // No overflow trap
            ALU_SUB, ALU_SUBU: aluRes = a - b;
            ALU_BEQ, ALU_BNE:  aluRes = a - b;     // Compare by difference
            ALU_LUI:           aluRes = b << 16;
            ALU_AND:           aluRes = a & b;
            ALU_OR:            aluRes = a | b;
            ALU_NOR:           aluRes = ~(a | b);
            ALU_XOR:           aluRes = a ^ b;
            ALU_SLL:           aluRes = b << shamt;
            ALU_SRL:           aluRes = b >> shamt;
            ALU_SRA:           aluRes = $signed(b) >>> shamt;  // Sign fill
            ALU_SLLV:          aluRes = b << varSh;
            ALU_SRLV:          aluRes = b >> varSh;
            ALU_SRAV:          aluRes = $signed(b) >>> varSh;
            ALU_SLT:           aluRes = word_t'($signed(a) < $signed(b));
            ALU_SLTU:          aluRes = word_t'(a < b);
            default:           aluRes = '0;    // NOP gives zero
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            vld <= 1'b0;
        end else if (load) begin
            vld <= inVld;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            result      <= aluRes;
            zero        <= resZero;
            taken       <= (op == ALU_BEQ) ? resZero : ((op == ALU_BNE) && !resZero);
            destOut     <= dest;
            regWriteOut <= regWrite && !isBranch;  // Branches never write back
        end
    end

    // Flag must agree with the registered result
    zeroMatchesResult: assert property (@(posedge clk) disable iff (!arstN)
        vld |-> (zero == (result == '0)))
        else $error("zero flag disagrees with result");

endmodule

`default_nettype wire

// ==== verilog/aluPkg.sv ====
`default_nettype none

`include "alu_params.svh"

package aluPkg;

    typedef logic [`ALU_DATA_WIDTH-1:0]    word_t;    // Operand or result word
    typedef logic [`ALU_REG_IDX_WIDTH-1:0] regIdx_t;  // Register number

    // ALU operation codes
    typedef enum logic [5:0] {
        ALU_ADD  = 6'd0,   // add, addi
        ALU_ADDU = 6'd1,   // addu, addiu
        ALU_SUB  = 6'd2,   // Signed subtract
        ALU_BEQ  = 6'd9,   // Branch if equal
        ALU_BNE  = 6'd10,  // Branch if not equal
        ALU_SRAV = 6'd15,  // Variable arithmetic right shift
        ALU_LUI  = 6'd17,  // Immediate into upper half
        ALU_AND  = 6'd18,  // and, andi
        ALU_OR   = 6'd19,  // or, ori
        ALU_NOR  = 6'd20,
        ALU_XOR  = 6'd21,  // xor, xori
        ALU_SLL  = 6'd23,  // Shift left by shamt
        ALU_SRL  = 6'd24,  // Logical right by shamt
        ALU_SRA  = 6'd28,  // Arithmetic right by shamt
        ALU_SLT  = 6'd30,  // Signed set on less than
        ALU_SLTU = 6'd31,  // Unsigned set on less than
        ALU_SLLV = 6'd36,
        ALU_SRLV = 6'd37,
        ALU_SUBU = 6'd45,
        ALU_NOP  = 6'd63   // Unknown encoding
    } aluOp_t;

    // How operand B is formed from the immediate
    typedef enum logic [1:0] {
        IMM_NONE  = 2'd0,  // Keep rt value
        IMM_SIGN  = 2'd1,  // Sign extended
        IMM_ZERO  = 2'd2,  // Zero extended
        IMM_UPPER = 2'd3   // Raw for lui
    } immKind_t;

endpackage

`default_nettype wire

// ==== verilog/execUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module execUnit (
    input  logic            clk,
    input  logic            arstN,
    input  logic            inReq,
    output logic            inAck,
    input  aluPkg::word_t   inInstr,
    input  aluPkg::word_t   inA,
    input  aluPkg::word_t   inB,
    output logic            outReq,
    input  logic            outAck,
    output aluPkg::word_t   outResult,
    output logic            outZero,
    output logic            outTaken,
    output logic            outRegWrite,
    output aluPkg::regIdx_t outDest
);

    import aluPkg::*;

    // Capture to decode
    logic  rxVld, decStall;
    word_t rxInstr, rxRs, rxRt;

    // Decode to operand select
    logic                        decVld, selStall, decRegWrite;
    aluOp_t                      decOp;
    logic [`ALU_SHAMT_WIDTH-1:0] decShamt;
    logic [15:0]                 decImm;
    immKind_t                    decImmKind;
    regIdx_t                     decDest;
    word_t                       decA, decB;

    // Operand select to ALU
    logic                        selVld, aluStall, selRegWrite;
    aluOp_t                      selOp;
    logic [`ALU_SHAMT_WIDTH-1:0] selShamt;
    regIdx_t                     selDest;
    word_t                       selA, selB;

    // ALU to sender
    logic    aluVld, aluZero, aluTaken, aluRegWrite, txStall;
    word_t   aluResult;
    regIdx_t aluDest;

    reqAckReceiver i_rx (
        .clk(clk), .arstN(arstN), .inReq(inReq), .inInstr(inInstr), .inA(inA), .inB(inB),
        .stall(decStall), .inAck(inAck), .vld(rxVld), .instr(rxInstr),
        .rsVal(rxRs), .rtVal(rxRt)
    );

    opDecoder i_dec (
        .clk(clk), .arstN(arstN), .inVld(rxVld), .instr(rxInstr), .rsVal(rxRs),
        .rtVal(rxRt), .stall(selStall), .vld(decVld), .op(decOp), .shamt(decShamt),
        .imm(decImm), .immKind(decImmKind), .dest(decDest), .regWrite(decRegWrite),
        .aVal(decA), .bVal(decB), .stallUp(decStall)
    );

    operandSelect i_sel (
        .clk(clk), .arstN(arstN), .inVld(decVld), .op(decOp), .shamt(decShamt),
        .imm(decImm), .immKind(decImmKind), .dest(decDest), .regWrite(decRegWrite),
        .aVal(decA), .bVal(decB), .stall(aluStall), .vld(selVld), .opOut(selOp),
        .shamtOut(selShamt), .destOut(selDest), .regWriteOut(selRegWrite),
        .opA(selA), .opB(selB), .stallUp(selStall)
    );

    alu i_alu (
        .clk(clk), .arstN(arstN), .inVld(selVld), .op(selOp), .shamt(selShamt),
        .dest(selDest), .regWrite(selRegWrite), .a(selA), .b(selB), .stall(txStall),
        .vld(aluVld), .result(aluResult), .zero(aluZero), .taken(aluTaken),
        .destOut(aluDest), .regWriteOut(aluRegWrite), .stallUp(aluStall)
    );

    reqAckSender i_tx (
        .clk(clk), .arstN(arstN), .inVld(aluVld), .result(aluResult), .zero(aluZero),
        .taken(aluTaken), .dest(aluDest), .regWrite(aluRegWrite), .outAck(outAck),
        .stall(txStall), .outReq(outReq), .outResult(outResult), .outZero(outZero),
        .outTaken(outTaken), .outRegWrite(outRegWrite), .outDest(outDest)
    );

endmodule

`default_nettype wire

// ==== verilog/opDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module opDecoder (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        inVld,
    input  aluPkg::word_t               instr,
    input  aluPkg::word_t               rsVal,
    input  aluPkg::word_t               rtVal,
    input  logic                        stall,
    output logic                        vld,
    output aluPkg::aluOp_t              op,
    output logic [`ALU_SHAMT_WIDTH-1:0] shamt,
    output logic [15:0]                 imm,
    output aluPkg::immKind_t            immKind,
    output aluPkg::regIdx_t             dest,
    output logic                        regWrite,
    output aluPkg::word_t               aVal,
    output aluPkg::word_t               bVal,
    output logic                        stallUp
);

    import aluPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       isRType;
    logic       load;
    aluOp_t     decOp;
    immKind_t   decImm;

    assign opcode  = instr[31:26];
    assign funct   = instr[5:0];
    assign isRType = (opcode == 6'h00);  // SPECIAL group
    assign load    = !vld || !stall;
    assign stallUp = vld && stall;

    // Operation from funct or opcode
    always_comb begin
        if (isRType) begin
            case (funct)
                6'h00:   decOp = ALU_SLL;
                6'h02:   decOp = ALU_SRL;
                6'h03:   decOp = ALU_SRA;
                6'h04:   decOp = ALU_SLLV;
                6'h06:   decOp = ALU_SRLV;
                6'h07:   decOp = ALU_SRAV;
                6'h20:   decOp = ALU_ADD;
                6'h21:   decOp = ALU_ADDU;
                6'h22:   decOp = ALU_SUB;
                6'h23:   decOp = ALU_SUBU;
                6'h24:   decOp = ALU_AND;
                6'h25:   decOp = ALU_OR;
                6'h26:   decOp = ALU_XOR;
                6'h27:   decOp = ALU_NOR;
                6'h2a:   decOp = ALU_SLT;
                6'h2b:   decOp = ALU_SLTU;
                default: decOp = ALU_NOP;
            endcase
        end else begin
            case (opcode)
                6'h04:   decOp = ALU_BEQ;
                6'h05:   decOp = ALU_BNE;
                6'h08:   decOp = ALU_ADD;   // addi
                6'h09:   decOp = ALU_ADDU;  // addiu
                6'h0a:   decOp = ALU_SLT;   // slti
                6'h0b:   decOp = ALU_SLTU;  // sltiu
                6'h0c:   decOp = ALU_AND;   // andi
                6'h0d:   decOp = ALU_OR;    // ori
                6'h0e:   decOp = ALU_XOR;   // xori
                6'h0f:   decOp = ALU_LUI;
                default: decOp = ALU_NOP;
            endcase
        end
    end

    // Immediate handling by opcode, R-type falls to none
    always_comb begin
        case (opcode)
            6'h08, 6'h09, 6'h0a, 6'h0b: decImm = IMM_SIGN;  // sltiu also sign extends
            6'h0c, 6'h0d, 6'h0e:        decImm = IMM_ZERO;
            6'h0f:                      decImm = IMM_UPPER;
            default:                    decImm = IMM_NONE;  // Branches keep rt
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            vld <= 1'b0;
        end else if (load) begin
            vld <= inVld;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            op       <= decOp;
            shamt    <= instr[6 +: `ALU_SHAMT_WIDTH];
            imm      <= instr[15:0];
            immKind  <= decImm;
            dest     <= isRType ? instr[11 +: `ALU_REG_IDX_WIDTH]    // rd
                                : instr[16 +: `ALU_REG_IDX_WIDTH];   // rt
            regWrite <= (decOp != ALU_NOP);  // Branches cleared later in ALU
            aVal     <= rsVal;
            bVal     <= rtVal;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/operandSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module operandSelect (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        inVld,
    input  aluPkg::aluOp_t              op,
    input  logic [`ALU_SHAMT_WIDTH-1:0] shamt,
    input  logic [15:0]                 imm,
    input  aluPkg::immKind_t            immKind,
    input  aluPkg::regIdx_t             dest,
    input  logic                        regWrite,
    input  aluPkg::word_t               aVal,
    input  aluPkg::word_t               bVal,
    input  logic                        stall,
    output logic                        vld,
    output aluPkg::aluOp_t              opOut,
    output logic [`ALU_SHAMT_WIDTH-1:0] shamtOut,
    output aluPkg::regIdx_t             destOut,
    output logic                        regWriteOut,
    output aluPkg::word_t               opA,
    output aluPkg::word_t               opB,
    output logic                        stallUp
);

    import aluPkg::*;

    logic  load;
    word_t selB;  // Operand B before the stage register

    assign load    = !vld || !stall;
    assign stallUp = vld && stall;

    always_comb begin
        case (immKind)
            IMM_SIGN:            selB = {{(`ALU_DATA_WIDTH-16){imm[15]}}, imm};
            IMM_ZERO, IMM_UPPER: selB = {{(`ALU_DATA_WIDTH-16){1'b0}}, imm};  // lui shifted in ALU
            default:             selB = bVal;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            vld <= 1'b0;
        end else if (load) begin
            vld <= inVld;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            opOut       <= op;
            shamtOut    <= shamt;
            destOut     <= dest;
            regWriteOut <= regWrite;
            opA         <= aVal;  // Always rs
            opB         <= selB;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/reqAckReceiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module reqAckReceiver (
    input  logic          clk,
    input  logic          arstN,
    input  logic          inReq,    // Four-phase request from source
    input  aluPkg::word_t inInstr,
    input  aluPkg::word_t inA,      // rs value
    input  aluPkg::word_t inB,      // rt value
    input  logic          stall,    // From decode stage
    output logic          inAck,
    output logic          vld,
    output aluPkg::word_t instr,
    output aluPkg::word_t rsVal,
    output aluPkg::word_t rtVal
);

    typedef enum logic {IDLE, ACKED} rxState_t;

    rxState_t state;
    logic     free;   // Stage register can take a new item
    logic     take;   // Capture on this edge

    assign free  = !vld || !stall;
    assign take  = (state == IDLE) && inReq && free;
    assign inAck = (state == ACKED);  // Held until source drops inReq

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
            vld   <= 1'b0;
        end else begin
            if (free) begin
                vld <= take;  // Refill or drain
            end
            case (state)
                IDLE:    if (take) state <= ACKED;
                ACKED:   if (!inReq) state <= IDLE;  // Return to zero
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            instr <= inInstr;
            rsVal <= inA;
            rtVal <= inB;
        end
    end

    // Ack may only answer a request seen on the previous edge
    inAckNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(inAck) |-> $past(inReq))
        else $error("inAck rose while inReq was low");

endmodule

`default_nettype wire

// ==== verilog/reqAckSender.sv ====
`timescale 1ns/1ps
`default_nettype none

module reqAckSender (
    input  logic            clk,
    input  logic            arstN,
    input  logic            inVld,
    input  aluPkg::word_t   result,
    input  logic            zero,
    input  logic            taken,
    input  aluPkg::regIdx_t dest,
    input  logic            regWrite,
    input  logic            outAck,      // Four-phase ack from sink
    output logic            stall,       // Back to ALU stage
    output logic            outReq,
    output aluPkg::word_t   outResult,
    output logic            outZero,
    output logic            outTaken,
    output logic            outRegWrite,
    output aluPkg::regIdx_t outDest
);

    typedef enum logic [1:0] {EMPTY, REQ, WAITLOW} txState_t;

    txState_t state;
    logic     load;

    assign load   = (state == EMPTY) && inVld;
    assign stall  = (state != EMPTY);   // Holding an undelivered result
    assign outReq = (state == REQ);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= EMPTY;
        end else begin
            case (state)
                EMPTY:   if (inVld) state <= REQ;
                REQ:     if (outAck) state <= WAITLOW;    // Drop request
                WAITLOW: if (!outAck) state <= EMPTY;     // Sink back to zero
                default: state <= EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            outResult   <= result;
            outZero     <= zero;
            outTaken    <= taken;
            outRegWrite <= regWrite;
            outDest     <= dest;
        end
    end

    // Data frozen for the whole request phase
    outDataStable: assert property (@(posedge clk) disable iff (!arstN)
        (outReq && $past(outReq)) |->
            $stable({outResult, outZero, outTaken, outRegWrite, outDest}))
        else $error("output data changed while outReq was high");

endmodule

`default_nettype wire
